/* verilog/c64_loader_pkg.sv */
`default_nettype none

package c64_loader_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int RAM_ADDR_W = 25;
	localparam int DL_OFS_W   = 25;

	// ========================================================================
	// Image indices and CRT layout
	// ========================================================================
	localparam logic [7:0] IDX_PRG     = 8'h02;
	localparam logic [7:0] IDX_CRT     = 8'h03;
	localparam logic [7:0] IDX_CRT_ALT = 8'hC0;

	localparam logic [RAM_ADDR_W-1:0] CRT_BASE       = 25'h100000;
	localparam logic [DL_OFS_W-1:0]   CRT_CHIP_START = 25'h40;
	// EXROM and GAME bytes follow the two id bytes
	localparam logic [DL_OFS_W-1:0]   CRT_ID_OFS     = 25'h16;

	localparam int CHIP_HDR_LEN    = 16;
	localparam int BANK_ALIGN_BITS = 13;

	// ========================================================================
	// Bundles
	// ========================================================================
	typedef struct packed {
		logic [DL_OFS_W-1:0] ofs;
		logic [7:0]          data;
	} dl_byte_t;

	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            data;
	} ram_wr_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
		logic        attached;
	} cart_info_t;

	typedef struct packed {
		logic [7:0]  btype;
		logic [15:0] num;
		logic [15:0] laddr;
		logic [15:0] size;
	} chip_bank_t;

endpackage

`default_nettype wire

/* verilog/image_parser.sv */
`timescale 1ns/1ns
`default_nettype none

module image_parser import c64_loader_pkg::*; #(
	parameter int ADDR_W = RAM_ADDR_W
) (
	input  wire             clk_sys,
	input  wire             reset_n,
	input  wire             dl_active_i,
	input  wire [7:0]       dl_index_i,
	input  wire             dl_wr_i,
	input  dl_byte_t        dl_byte_i,
	input  wire             chip_payload_i,
	input  wire             chip_start_i,
	output logic            restart_o,
	output logic            chip_byte_o,
	output logic [7:0]      chip_data_o,
	output logic            wr_req_o,
	output ram_wr_t         wr_o,
	output cart_info_t      cart_info_o
);

	localparam logic [ADDR_W-1:0] ALIGN_MASK = ADDR_W'((1 << BANK_ALIGN_BITS) - 1);

	logic              is_prg;
	logic              is_crt;
	logic              prg_payload;
	logic              take;
	logic [ADDR_W-1:0] load_addr;
	logic              old_active;
	logic              attached;
	logic [15:0]       cart_id;
	logic [7:0]        cart_exrom;
	logic [7:0]        cart_game;

	assign is_prg = (dl_index_i == IDX_PRG);
	assign is_crt = (dl_index_i == IDX_CRT) || (dl_index_i == IDX_CRT_ALT);

	// PRG bytes after the two address bytes go straight to RAM
	assign prg_payload = dl_wr_i && is_prg && (dl_byte_i.ofs >= DL_OFS_W'(2));

	// CRT bytes from the first CHIP packet on belong to the header walker
	assign chip_byte_o = dl_wr_i && is_crt && (dl_byte_i.ofs >= CRT_CHIP_START);
	assign chip_data_o = dl_byte_i.data;
	assign restart_o   = dl_wr_i && is_crt && (dl_byte_i.ofs == '0);

	assign take = prg_payload || chip_payload_i;

	// ========================================================================
	// Load address and write request
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			load_addr  <= '0;
			wr_req_o   <= 1'b0;
			old_active <= 1'b0;
			attached   <= 1'b0;
		end else begin
			old_active <= dl_active_i;
			wr_req_o   <= take;

			// Load address comes little endian in front of the PRG data
			if (dl_wr_i && is_prg) begin
				if (dl_byte_i.ofs == '0)
					load_addr <= ADDR_W'(dl_byte_i.data);
				else if (dl_byte_i.ofs == DL_OFS_W'(1))
					load_addr[15:8] <= dl_byte_i.data;
			end

			if (restart_o)
				load_addr <= ADDR_W'(CRT_BASE);

			// New packet starts on the next bank boundary
			if (chip_start_i && ((load_addr & ALIGN_MASK) != '0))
				load_addr <= (load_addr | ALIGN_MASK) + 1'b1;

			if (take)
				load_addr <= load_addr + 1'b1;

			// Cartridge counts as attached once its download is over
			if (is_crt && (old_active != dl_active_i))
				attached <= old_active;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			wr_o.addr <= RAM_ADDR_W'(load_addr);
			wr_o.data <= dl_byte_i.data;
		end
	end

	// CRT file header fields
	always_ff @(posedge clk_sys) begin
		if (dl_wr_i && is_crt) begin
			if (dl_byte_i.ofs == CRT_ID_OFS)
				cart_id[15:8] <= dl_byte_i.data;
			if (dl_byte_i.ofs == CRT_ID_OFS + DL_OFS_W'(1))
				cart_id[7:0] <= dl_byte_i.data;
			if (dl_byte_i.ofs == CRT_ID_OFS + DL_OFS_W'(2))
				cart_exrom <= dl_byte_i.data;
			if (dl_byte_i.ofs == CRT_ID_OFS + DL_OFS_W'(3))
				cart_game <= dl_byte_i.data;
		end
	end

	assign cart_info_o = '{id: cart_id, exrom: cart_exrom, game: cart_game, attached: attached};

endmodule

`default_nettype wire

/* verilog/crt_chip_header.sv */
`timescale 1ns/1ns
`default_nettype none

module crt_chip_header import c64_loader_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset_n,
	input  wire        restart_i,
	input  wire        chip_byte_i,
	input  wire [7:0]  chip_data_i,
	output logic       chip_payload_o,
	output logic       chip_start_o,
	output chip_bank_t bank_o,
	output logic       bank_wr_o
);

	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        idle;

	// Idle between packets with no header byte counted and no payload left
	assign idle = (hdr_cnt == 4'd0) && (blk_len == '0);

	assign chip_start_o   = chip_byte_i && idle;
	assign chip_payload_o = chip_byte_i && (hdr_cnt == 4'd0) && (blk_len != '0);

	// ========================================================================
	// Header counter and remaining packet length
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			hdr_cnt   <= 4'd0;
			blk_len   <= '0;
			bank_wr_o <= 1'b0;
		end else begin
			bank_wr_o <= 1'b0;
			if (restart_i) begin
				hdr_cnt <= 4'd0;
				blk_len <= '0;
			end else if (chip_byte_i) begin
				if (idle) begin
					hdr_cnt <= 4'd1;
				end else if (hdr_cnt != 4'd0) begin
					// Wraps back to zero after byte 15
					hdr_cnt <= hdr_cnt + 4'd1;
					case (hdr_cnt)
						4'd4: blk_len[31:24] <= chip_data_i;
						4'd5: blk_len[23:16] <= chip_data_i;
						4'd6: blk_len[15:8]  <= chip_data_i;
						4'd7: blk_len[7:0]   <= chip_data_i;
						// Packet length includes its own header
						4'd8: blk_len <= blk_len - 32'(CHIP_HDR_LEN);
						4'd15: bank_wr_o <= 1'b1;
						default: ;
					endcase
				end else begin
					blk_len <= blk_len - 32'd1;
				end
			end
		end
	end

	// Bank fields are big endian
	always_ff @(posedge clk_sys) begin
		if (chip_byte_i && !restart_i) begin
			case (hdr_cnt)
				4'd9:  bank_o.btype       <= chip_data_i;
				4'd10: bank_o.num[15:8]   <= chip_data_i;
				4'd11: bank_o.num[7:0]    <= chip_data_i;
				4'd12: bank_o.laddr[15:8] <= chip_data_i;
				4'd13: bank_o.laddr[7:0]  <= chip_data_i;
				4'd14: bank_o.size[15:8]  <= chip_data_i;
				4'd15: bank_o.size[7:0]   <= chip_data_i;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/slot_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module slot_writer import c64_loader_pkg::*; (
	input  wire     clk_sys,
	input  wire     reset_n,
	input  wire     wr_req_i,
	input  ram_wr_t wr_i,
	input  wire     slot_i,
	output logic    dl_wait_o,
	output logic    ram_we_o,
	output ram_wr_t ram_wr_o
);

	logic    pending;
	logic    used;
	logic    slot_d;
	logic    serve;
	ram_wr_t held;

	// Only the first cycle of a slot may start a write
	assign serve = slot_i && !slot_d && pending;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pending <= 1'b0;
			used    <= 1'b0;
			slot_d  <= 1'b0;
		end else begin
			slot_d <= slot_i;
			if (wr_req_i)
				pending <= 1'b1;
			else if (serve)
				pending <= 1'b0;

			// Slot belongs to this write until it ends
			if (serve)
				used <= 1'b1;
			else if (!slot_i)
				used <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_req_i)
			held <= wr_i;
		if (serve)
			ram_wr_o <= held;
	end

	assign ram_we_o  = used && slot_i;
	assign dl_wait_o = wr_req_i || pending;

endmodule

`default_nettype wire

/* verilog/c64_loader_top.sv */
`timescale 1ns/1ns
`default_nettype none

module c64_loader_top import c64_loader_pkg::*; #(
	parameter int ADDR_W = RAM_ADDR_W
) (
	input  wire        clk_sys,
	input  wire        reset_n,
	input  wire        dl_active_i,
	input  wire [7:0]  dl_index_i,
	input  wire        dl_wr_i,
	input  dl_byte_t   dl_byte_i,
	input  wire        slot_i,
	output logic       dl_wait_o,
	output logic       ram_we_o,
	output ram_wr_t    ram_wr_o,
	output cart_info_t cart_info_o,
	output chip_bank_t bank_o,
	output logic       bank_wr_o
);

	// RAM writes carry the package address width
	if (ADDR_W > RAM_ADDR_W) begin : g_addr_w_check
		$error("ADDR_W %0d exceeds RAM address width %0d", ADDR_W, RAM_ADDR_W);
	end

	logic       restart;
	logic       chip_byte;
	logic [7:0] chip_data;
	logic       chip_payload;
	logic       chip_start;
	logic       wr_req;
	ram_wr_t    wr;

	// ========================================================================
	// Host byte stream to RAM writes
	// ========================================================================
	image_parser #(
		.ADDR_W(ADDR_W)
	) u_image_parser (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_byte_i      (dl_byte_i),
		.chip_payload_i (chip_payload),
		.chip_start_i   (chip_start),
		.restart_o      (restart),
		.chip_byte_o    (chip_byte),
		.chip_data_o    (chip_data),
		.wr_req_o       (wr_req),
		.wr_o           (wr),
		.cart_info_o    (cart_info_o)
	);

	crt_chip_header u_crt_chip_header (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.restart_i      (restart),
		.chip_byte_i    (chip_byte),
		.chip_data_i    (chip_data),
		.chip_payload_o (chip_payload),
		.chip_start_o   (chip_start),
		.bank_o         (bank_o),
		.bank_wr_o      (bank_wr_o)
	);

	slot_writer u_slot_writer (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.wr_req_i  (wr_req),
		.wr_i      (wr),
		.slot_i    (slot_i),
		.dl_wait_o (dl_wait_o),
		.ram_we_o  (ram_we_o),
		.ram_wr_o  (ram_wr_o)
	);

endmodule

`default_nettype wire

/* testbench/c64_loader_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module c64_loader_sva (
	input wire clk_sys,
	input wire reset_n,
	input wire slot_i,
	input wire ram_we_o,
	input wire bank_wr_o,
	input wire dl_wait_o
);

	// RAM is only touched inside a memory slot
	a_we_in_slot: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ram_we_o |-> slot_i)
		else $error("ram_we_o high outside a slot");

	a_bank_pulse: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_wr_o |=> !bank_wr_o)
		else $error("bank_wr_o longer than one cycle");

	a_reset_idle: assert property (@(posedge clk_sys)
		!reset_n |=> (!dl_wait_o && !ram_we_o))
		else $error("dl_wait_o or ram_we_o high after reset");

endmodule

bind c64_loader_top c64_loader_sva u_sva (
	.clk_sys   (clk_sys),
	.reset_n   (reset_n),
	.slot_i    (slot_i),
	.ram_we_o  (ram_we_o),
	.bank_wr_o (bank_wr_o),
	.dl_wait_o (dl_wait_o)
);

`default_nettype wire

/* testbench/tb_c64_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_c64_loader import c64_loader_pkg::*; ();

	typedef struct packed {
		logic [7:0]  idx;
		logic [24:0] ofs;
		logic [7:0]  data;
		logic        wr;
		logic [24:0] addr;
		logic        last;
	} row_t;

	logic       clk_sys;
	logic       reset_n;
	logic       dl_active_i;
	logic [7:0] dl_index_i;
	logic       dl_wr_i;
	dl_byte_t   dl_byte_i;
	logic       slot_i;
	logic       dl_wait_o;
	logic       ram_we_o;
	ram_wr_t    ram_wr_o;
	cart_info_t cart_info_o;
	chip_bank_t bank_o;
	logic       bank_wr_o;

	row_t       tbl[$];
	ram_wr_t    exp_wr[$];
	chip_bank_t exp_bank[$];
	logic       we_d;
	logic       wait_d;
	int         cycles = 0;
	int         limit = 1000;

	c64_loader_top #(
		.ADDR_W(RAM_ADDR_W)
	) u_dut (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_byte_i   (dl_byte_i),
		.slot_i      (slot_i),
		.dl_wait_o   (dl_wait_o),
		.ram_we_o    (ram_we_o),
		.ram_wr_o    (ram_wr_o),
		.cart_info_o (cart_info_o),
		.bank_o      (bank_o),
		.bank_wr_o   (bank_wr_o)
	);

	task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
		if (act !== exp) begin
			$display("ERR t=%0t %s: got %h expected %h", $time, name, act, exp);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input logic [7:0] idx, input logic [24:0] ofs, input logic [7:0] data,
			input logic wr, input logic [24:0] addr, input logic last);
		row_t r;
		r = '{idx, ofs, data, wr, addr, last};
		tbl.push_back(r);
	endtask

	// One CHIP packet of 16 header bytes and its payload from base upward
	task automatic add_chip(input logic [24:0] ofs, input logic [7:0] plen, input logic [15:0] bank,
			input logic [15:0] laddr, input logic [24:0] base, input logic last);
		logic [7:0] hdr [16];
		chip_bank_t b;
		b = '{btype: 8'h00, num: bank, laddr: laddr, size: 16'h2000};
		hdr = '{8'h43, 8'h48, 8'h49, 8'h50, 8'h00, 8'h00, 8'h00, 8'd16 + plen,
			8'h00, b.btype, bank[15:8], bank[7:0], laddr[15:8], laddr[7:0], 8'h20, 8'h00};
		exp_bank.push_back(b);
		for (int i = 0; i < 16; i++)
			add_row(IDX_CRT, ofs + 25'(i), hdr[i], 1'b0, 25'h0, 1'b0);
		for (int i = 0; i < int'(plen); i++)
			add_row(IDX_CRT, ofs + 25'(16 + i), 8'($urandom), 1'b1, base + 25'(i),
				last && (i == int'(plen) - 1));
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Memory slots at random gaps
	initial begin
		slot_i = 1'b0;
		wait (reset_n === 1'b1);
		forever begin
			repeat ($urandom_range(9, 2)) @(negedge clk_sys);
			slot_i = 1'b1;
			repeat ($urandom_range(4, 2)) @(negedge clk_sys);
			slot_i = 1'b0;
		end
	end

	// ========================================================================
	// RAM and bank monitors, run limit
	// ========================================================================
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		we_d   <= reset_n && ram_we_o;
		wait_d <= reset_n && dl_wait_o;
		if (cycles > limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Verification failed");
			$fatal(1, "timeout");
		end else if (reset_n && ram_we_o && !we_d && exp_wr.size() == 0) begin
			$display("RAM write at t=%0t with no write expected", $time);
			$display("Verification failed");
			$fatal(1, "unexpected write");
		end else if (reset_n && bank_wr_o && exp_bank.size() == 0) begin
			$display("Bank strobe at t=%0t with no CHIP header expected", $time);
			$display("Verification failed");
			$fatal(1, "unexpected bank strobe");
		end else begin
			if (reset_n && ram_we_o) begin
				check_val("slot_i", 64'(slot_i), 64'h1);
				// First cycle of a write only
				if (!we_d) begin
					check_val("ram_wr_o.addr", 64'(ram_wr_o.addr), 64'(exp_wr[0].addr));
					check_val("ram_wr_o.data", 64'(ram_wr_o.data), 64'(exp_wr[0].data));
					void'(exp_wr.pop_front());
				end
			end
			// Wait level drops only once the write is under way
			if (reset_n && wait_d && !dl_wait_o)
				check_val("ram_we_o", 64'(ram_we_o), 64'h1);
			if (reset_n && bank_wr_o) begin
				check_val("bank_o", 64'(bank_o), 64'(exp_bank[0]));
				void'(exp_bank.pop_front());
			end
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		row_t    r;
		ram_wr_t w;
		void'($urandom(42379));
		reset_n     = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_wr_i     = 1'b0;
		dl_byte_i   = '0;

		// PRG with load address 0801 followed by CRT header fields and two packets
		add_row(IDX_PRG, 25'h0, 8'h01, 1'b0, 25'h0, 1'b0);
		add_row(IDX_PRG, 25'h1, 8'h08, 1'b0, 25'h0, 1'b0);
		for (int i = 0; i < 5; i++)
			add_row(IDX_PRG, 25'(2 + i), 8'($urandom), 1'b1, 25'h801 + 25'(i), i == 4);
		add_row(IDX_CRT, 25'h0, 8'h43, 1'b0, 25'h0, 1'b0);
		add_row(IDX_CRT, 25'h16, 8'h00, 1'b0, 25'h0, 1'b0);
		add_row(IDX_CRT, 25'h17, 8'h13, 1'b0, 25'h0, 1'b0);
		add_row(IDX_CRT, 25'h18, 8'h00, 1'b0, 25'h0, 1'b0);
		add_row(IDX_CRT, 25'h19, 8'h01, 1'b0, 25'h0, 1'b0);
		add_chip(25'h40, 8'd5, 16'h0001, 16'h8000, 25'h100000, 1'b0);
		add_chip(25'h55, 8'd2, 16'h0002, 16'hA000, 25'h102000, 1'b1);
		limit = 40 * tbl.size() + 200;

		repeat (4) @(negedge clk_sys);
		reset_n = 1'b1;
		@(negedge clk_sys);
		check_val("dl_wait_o", 64'(dl_wait_o), 64'h0);
		check_val("ram_we_o", 64'(ram_we_o), 64'h0);
		check_val("bank_wr_o", 64'(bank_wr_o), 64'h0);
		check_val("cart_info_o.attached", 64'(cart_info_o.attached), 64'h0);

		foreach (tbl[n]) begin
			r = tbl[n];
			if (!dl_active_i) begin
				dl_index_i  = r.idx;
				dl_active_i = 1'b1;
				@(negedge clk_sys);
			end
			dl_wr_i        = 1'b1;
			dl_byte_i.ofs  = r.ofs;
			dl_byte_i.data = r.data;
			if (r.wr) begin
				w.addr = r.addr;
				w.data = r.data;
				exp_wr.push_back(w);
			end
			@(negedge clk_sys);
			dl_wr_i = 1'b0;
			check_val("dl_wait_o", 64'(dl_wait_o), 64'(r.wr));
			if (r.idx == IDX_CRT)
				check_val("cart_info_o.attached", 64'(cart_info_o.attached), 64'h0);
			repeat (3) @(negedge clk_sys);
			while (dl_wait_o)
				@(negedge clk_sys);
			if (r.last) begin
				dl_active_i = 1'b0;
				repeat (2) @(negedge clk_sys);
				if (r.idx == IDX_CRT)
					check_val("cart_info_o", 64'(cart_info_o),
						64'({16'h0013, 8'h00, 8'h01, 1'b1}));
			end
		end

		repeat (4) @(negedge clk_sys);
		if (exp_wr.size() != 0 || exp_bank.size() != 0) begin
			$display("RAM writes or bank strobes still missing at the end of the run");
			$display("Verification failed");
			$fatal(1, "missing DUT activity");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* c64_loader.f */
verilog/c64_loader_pkg.sv
verilog/image_parser.sv
verilog/crt_chip_header.sv
verilog/slot_writer.sv
verilog/c64_loader_top.sv
testbench/c64_loader_sva.sv
testbench/tb_c64_loader.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_c64_loader \
	-f c64_loader.f -o tb_c64_loader
./obj_dir/tb_c64_loader
